//--- source/rv_decode_pkg.sv
/*
 * RV32I decode package
 * Opcodes, field widths, memory sizes and ALU operations shared by the decode stage
 */
package rv_decode_pkg;

    ////////////////////
    // Widths and types
    ////////////////////
    localparam int XLEN = 32;               // Data path width

    typedef logic [XLEN-1:0] word_t;        // Instruction or immediate
    typedef logic [6:0]      opcode_t;
    typedef logic [4:0]      reg_addr_t;    // rs1, rs2, rd
    typedef logic [2:0]      func3_t;

    ////////////////////
    // Opcodes
    ////////////////////
    localparam opcode_t OPC_R_TYPE  = 7'b0110011;
    localparam opcode_t OPC_I_ARITH = 7'b0010011;
    localparam opcode_t OPC_LOAD    = 7'b0000011;
    localparam opcode_t OPC_JALR    = 7'b1100111;
    localparam opcode_t OPC_SYSTEM  = 7'b1110011;  // ECALL / EBREAK / CSR
    localparam opcode_t OPC_STORE   = 7'b0100011;
    localparam opcode_t OPC_BRANCH  = 7'b1100011;
    localparam opcode_t OPC_LUI     = 7'b0110111;
    localparam opcode_t OPC_AUIPC   = 7'b0010111;
    localparam opcode_t OPC_JAL     = 7'b1101111;

    // Coarse ALU class from the main decoder
    typedef logic [1:0] alu_class_t;
    localparam alu_class_t ALU_CLASS_ADD    = 2'b00;  // Address / immediate math
    localparam alu_class_t ALU_CLASS_BRANCH = 2'b01;  // Compare
    localparam alu_class_t ALU_CLASS_FUNC   = 2'b10;  // Decode from func3

    // Load / store access size
    typedef logic [1:0] data_size_t;
    localparam data_size_t SIZE_NONE = 2'b00;  // Also illegal func3
    localparam data_size_t SIZE_BYTE = 2'b01;
    localparam data_size_t SIZE_HALF = 2'b10;
    localparam data_size_t SIZE_WORD = 2'b11;

    ////////////////////
    // ALU operations
    ////////////////////
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

endpackage

//--- source/rv_ctrl_if.sv
/*
 * Main control bundle
 * Carries the decoded control fields from the base integer control unit to its users
 */
interface rv_ctrl_if;
    import rv_decode_pkg::*;

    logic       reg_write;   // Register file write enable
    logic       mem_read;    // Load
    logic       mem_write;   // Store
    logic       alu_src;     // Immediate as ALU operand B
    logic       mem_to_reg;  // Writeback from memory
    logic       branch;
    logic       jump;        // JAL / JALR
    alu_class_t alu_class;
    data_size_t data_size;

    // Main decoder drives everything
    modport producer (output reg_write, mem_read, mem_write, alu_src, mem_to_reg,
                      branch, jump, alu_class, data_size);

    modport consumer (input reg_write, mem_read, mem_write, alu_src, mem_to_reg,
                      branch, jump, alu_class, data_size);

endinterface

//--- source/base_integer_ctrl_unit.sv
/*
 * Base integer control unit
 * Decodes opcode and func3 into the main RV32I control fields
 */
module base_integer_ctrl_unit (
    input  rv_decode_pkg::opcode_t i_opcode,  // Instruction opcode field
    input  rv_decode_pkg::func3_t  i_func3,   // Instruction func3 field
    rv_ctrl_if.producer            ctrl       // Decoded control fields
);
    import rv_decode_pkg::*;

    data_size_t load_size;   // Size from func3 for loads
    data_size_t store_size;  // Same for stores

    ////////////////////
    // Access size
    ////////////////////
    always_comb begin
        case (i_func3)
            3'b000, 3'b100: load_size = SIZE_BYTE;  // LB, LBU
            3'b001, 3'b101: load_size = SIZE_HALF;  // LH, LHU
            3'b010:         load_size = SIZE_WORD;  // LW
            default:        load_size = SIZE_NONE;  // Illegal
        endcase
    end

    always_comb begin
        case (i_func3)
            3'b000:  store_size = SIZE_BYTE;  // SB
            3'b001:  store_size = SIZE_HALF;  // SH
            3'b010:  store_size = SIZE_WORD;  // SW
            default: store_size = SIZE_NONE;
        endcase
    end

    ////////////////////
    // Main decode
    ////////////////////
    always_comb begin
        // Unknown opcode leaves all zeros
        ctrl.reg_write  = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.alu_class  = ALU_CLASS_ADD;
        ctrl.data_size  = SIZE_NONE;
        case (i_opcode)
            OPC_R_TYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = ALU_CLASS_FUNC;
            end
            OPC_I_ARITH, OPC_JALR, OPC_SYSTEM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.jump      = (i_opcode == OPC_JALR);
                // SYSTEM stays in the add class
                ctrl.alu_class = (i_opcode == OPC_SYSTEM) ? ALU_CLASS_ADD : ALU_CLASS_FUNC;
            end
            OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;          // Base + offset
                ctrl.mem_to_reg = 1'b1;
                ctrl.data_size  = load_size;
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.data_size = store_size;
            end
            OPC_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.alu_class = ALU_CLASS_BRANCH;  // rs1 - rs2 compare
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;              // Link register
                ctrl.jump      = 1'b1;
            end
            default: ;
        endcase
    end

    // No opcode may both load and store
    always_comb begin
        assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("mem_read and mem_write high together, opcode %h", i_opcode);
    end

endmodule

//--- source/alu_ctrl_unit.sv
/*
 * ALU control unit
 * Maps the coarse ALU class and the function fields onto a concrete ALU operation
 */
module alu_ctrl_unit (
    rv_ctrl_if.consumer             ctrl,        // alu_class and alu_src used
    input  rv_decode_pkg::func3_t   i_func3,
    input  logic                    i_func7_b5,  // Instruction bit 30
    output rv_decode_pkg::alu_op_t  o_alu_op
);
    import rv_decode_pkg::*;

    ////////////////////
    // Operation select
    ////////////////////
    always_comb begin
        case (ctrl.alu_class)
            ALU_CLASS_ADD:    o_alu_op = ALU_ADD;  // Loads, stores, LUI, AUIPC, JAL
            ALU_CLASS_BRANCH: o_alu_op = ALU_SUB;  // Compare by subtraction
            ALU_CLASS_FUNC: begin
                case (i_func3)
                    // Bit 30 of an ADDI is immediate data, not SUB
                    3'b000: o_alu_op = (i_func7_b5 && !ctrl.alu_src) ? ALU_SUB : ALU_ADD;
                    3'b001: o_alu_op = ALU_SLL;
                    3'b010: o_alu_op = ALU_SLT;
                    3'b011: o_alu_op = ALU_SLTU;
                    3'b100: o_alu_op = ALU_XOR;
                    // SRAI keeps bit 30 as well
                    3'b101: o_alu_op = i_func7_b5 ? ALU_SRA : ALU_SRL;
                    3'b110: o_alu_op = ALU_OR;
                    default: o_alu_op = ALU_AND;  // 111
                endcase
            end
            default: o_alu_op = ALU_ADD;          // Class 11 unused
        endcase
    end

    // Guards against an undecoded class reaching execute
    always_comb begin
        assert (!$isunknown(o_alu_op))
            else $error("ALU operation unknown, class %b func3 %b",
                        ctrl.alu_class, i_func3);
    end

endmodule

//--- source/imm_gen.sv
/*
 * Immediate generator
 * Builds the sign-extended I, S, B, U or J immediate selected by the opcode
 */
module imm_gen (
    input  rv_decode_pkg::word_t i_instr,  // Full instruction
    output rv_decode_pkg::word_t o_imm     // Sign-extended immediate
);
    import rv_decode_pkg::*;

    opcode_t opcode;
    logic    sign;  // Always instruction bit 31
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;

    assign opcode = i_instr[6:0];
    assign sign   = i_instr[31];

    ////////////////////
    // Format layouts
    ////////////////////
    assign imm_i = {{(XLEN-12){sign}}, i_instr[31:20]};
    assign imm_s = {{(XLEN-12){sign}}, i_instr[31:25], i_instr[11:7]};

    // Branch offset is halfword aligned
    assign imm_b = {{(XLEN-13){sign}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};

    assign imm_u = {i_instr[31:12], 12'b0};  // Upper 20 bits

    assign imm_j = {{(XLEN-21){sign}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    ////////////////////
    // Format select
    ////////////////////
    always_comb begin
        case (opcode)
            OPC_I_ARITH,
            OPC_LOAD,
            OPC_JALR,
            OPC_SYSTEM:         o_imm = imm_i;
            OPC_STORE:          o_imm = imm_s;
            OPC_BRANCH:         o_imm = imm_b;
            OPC_LUI, OPC_AUIPC: o_imm = imm_u;
            OPC_JAL:            o_imm = imm_j;
            default:            o_imm = '0;    // R-type has none
        endcase
    end

endmodule

//--- source/decode_stage.sv
/*
 * RV32I decode stage
 * Splits register fields, decodes control, ALU op and immediate,
 * and registers everything once with bubble gating on i_valid
 */
module decode_stage (
    input  logic                      i_clk,
    input  logic                      i_rst,        // Sync, active high
    input  logic                      i_valid,      // Instruction present
    input  rv_decode_pkg::word_t      i_instr,
    output logic                      o_valid,
    output rv_decode_pkg::reg_addr_t  o_rs1,
    output rv_decode_pkg::reg_addr_t  o_rs2,
    output rv_decode_pkg::reg_addr_t  o_rd,
    output rv_decode_pkg::func3_t     o_func3,      // For signed/unsigned loads
    output rv_decode_pkg::word_t      o_imm,
    output rv_decode_pkg::alu_op_t    o_alu_op,
    output logic                      o_reg_write,
    output logic                      o_mem_read,
    output logic                      o_mem_write,
    output logic                      o_alu_src,
    output logic                      o_mem_to_reg,
    output logic                      o_branch,
    output logic                      o_jump,
    output rv_decode_pkg::data_size_t o_data_size
);
    import rv_decode_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    func3_t    func3;
    word_t     imm;     // From imm_gen
    alu_op_t   alu_op;  // From alu_ctrl_unit

    ////////////////////
    // Field slicing
    ////////////////////
    assign rs1   = i_instr[19:15];
    assign rs2   = i_instr[24:20];
    assign rd    = i_instr[11:7];
    assign func3 = i_instr[14:12];

    rv_ctrl_if u_ctrl_if ();

    base_integer_ctrl_unit u_base_ctrl (
        .i_opcode (i_instr[6:0]),
        .i_func3  (func3),
        .ctrl     (u_ctrl_if.producer)
    );

    alu_ctrl_unit u_alu_ctrl (
        .ctrl       (u_ctrl_if.consumer),
        .i_func3    (func3),
        .i_func7_b5 (i_instr[30]),
        .o_alu_op   (alu_op)
    );

    imm_gen u_imm_gen (
        .i_instr (i_instr),
        .o_imm   (imm)
    );

    ////////////////////
    // Pipeline register
    ////////////////////
    // Valid and enables, bubble when i_valid low
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_branch    <= 1'b0;
            o_jump      <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_reg_write <= i_valid & u_ctrl_if.reg_write;
            o_mem_read  <= i_valid & u_ctrl_if.mem_read;
            o_mem_write <= i_valid & u_ctrl_if.mem_write;
            o_branch    <= i_valid & u_ctrl_if.branch;
            o_jump      <= i_valid & u_ctrl_if.jump;
        end
    end

    // Data fields load every cycle
    always_ff @(posedge i_clk) begin
        o_rs1        <= rs1;
        o_rs2        <= rs2;
        o_rd         <= rd;
        o_func3      <= func3;
        o_imm        <= imm;
        o_alu_op     <= alu_op;
        o_alu_src    <= u_ctrl_if.alu_src;
        o_mem_to_reg <= u_ctrl_if.mem_to_reg;
        o_data_size  <= u_ctrl_if.data_size;
    end

    // A bubble never carries a side effect downstream
    a_bubble_quiet : assert property (@(posedge i_clk) disable iff (i_rst)
        !o_valid |-> !(o_reg_write || o_mem_read || o_mem_write || o_branch || o_jump))
        else $error("Enable high on an invalid slot");

endmodule

//--- sim/tb_clk_gen.sv
/*
 * Testbench clock source
 * Free-running clock with a 20 ns period
 */
module tb_clk_gen (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;  // Half period
    end

endmodule

//--- sim/tb_decode_stage.sv
/*
 * Decode stage testbench
 * Table of instructions with expected decode, applied in a loop with random
 * register fields, and a watchdog
 */
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_decode_pkg::*;

    typedef struct packed {
        word_t      instr;  // Template, free register fields zero
        logic       valid;
        logic [2:0] free;   // Random fields {rd, rs1, rs2}
        logic [6:0] ctrl;   // {reg_write, mem_read, mem_write, alu_src, mem_to_reg, branch, jump}
        data_size_t size;
        alu_op_t    op;
        word_t      imm;
    } entry_t;

    logic       i_clk;
    logic       i_rst;
    logic       i_valid;
    word_t      i_instr;
    logic       o_valid;
    reg_addr_t  o_rs1, o_rs2, o_rd;
    func3_t     o_func3;
    word_t      o_imm;
    alu_op_t    o_alu_op;
    logic       o_reg_write, o_mem_read, o_mem_write, o_alu_src, o_mem_to_reg, o_branch, o_jump;
    data_size_t o_data_size;

    entry_t      table_q[$];
    logic        table_built = 1'b0;
    logic [31:0] rand_state;
    string       phase;           // Shown in error lines

    tb_clk_gen u_clk_gen (.o_clk(i_clk));

    decode_stage u_dut (.*);

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s %s got %h expected %h", phase, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic add_entry(input word_t instr, input logic valid, input logic [2:0] free,
                             input logic [6:0] ctrl, input data_size_t size,
                             input alu_op_t op, input word_t imm);
        table_q.push_back(entry_t'{instr, valid, free, ctrl, size, op, imm});
    endtask

    task automatic build_table();
        // R-type
        add_entry(32'h0000_0033, 1'b1, 3'b111, 7'b1000000, SIZE_NONE, ALU_ADD, 32'h0);
        add_entry(32'h4000_0033, 1'b1, 3'b111, 7'b1000000, SIZE_NONE, ALU_SUB, 32'h0);
        add_entry(32'h0000_5033, 1'b1, 3'b111, 7'b1000000, SIZE_NONE, ALU_SRL, 32'h0);
        add_entry(32'h4000_5033, 1'b1, 3'b111, 7'b1000000, SIZE_NONE, ALU_SRA, 32'h0);
        // I-arith, ADDI with bit 30 set, SRAI, ANDI
        add_entry(32'hC000_0013, 1'b1, 3'b110, 7'b1001000, SIZE_NONE, ALU_ADD, 32'hFFFF_FC00);
        add_entry(32'h4030_5013, 1'b1, 3'b110, 7'b1001000, SIZE_NONE, ALU_SRA, 32'h0000_0403);
        add_entry(32'h0FF0_7013, 1'b1, 3'b110, 7'b1001000, SIZE_NONE, ALU_AND, 32'h0000_00FF);
        // Loads LB LH LW LBU and illegal func3
        add_entry(32'hFFC0_0003, 1'b1, 3'b110, 7'b1101100, SIZE_BYTE, ALU_ADD, 32'hFFFF_FFFC);
        add_entry(32'h0080_1003, 1'b1, 3'b110, 7'b1101100, SIZE_HALF, ALU_ADD, 32'h0000_0008);
        add_entry(32'h7FF0_2003, 1'b1, 3'b110, 7'b1101100, SIZE_WORD, ALU_ADD, 32'h0000_07FF);
        add_entry(32'h0000_4003, 1'b1, 3'b110, 7'b1101100, SIZE_BYTE, ALU_ADD, 32'h0);
        add_entry(32'h0000_3003, 1'b1, 3'b110, 7'b1101100, SIZE_NONE, ALU_ADD, 32'h0);
        // Stores SB SH SW and illegal func3
        add_entry(32'hFE00_0FA3, 1'b1, 3'b011, 7'b0011000, SIZE_BYTE, ALU_ADD, 32'hFFFF_FFFF);
        add_entry(32'h0200_1223, 1'b1, 3'b011, 7'b0011000, SIZE_HALF, ALU_ADD, 32'h0000_0024);
        add_entry(32'h0000_2023, 1'b1, 3'b011, 7'b0011000, SIZE_WORD, ALU_ADD, 32'h0);
        add_entry(32'h0000_4023, 1'b1, 3'b011, 7'b0011000, SIZE_NONE, ALU_ADD, 32'h0);
        // Branches, imm -8 and +2048
        add_entry(32'hFE00_0CE3, 1'b1, 3'b011, 7'b0000010, SIZE_NONE, ALU_SUB, 32'hFFFF_FFF8);
        add_entry(32'h0000_00E3, 1'b1, 3'b011, 7'b0000010, SIZE_NONE, ALU_SUB, 32'h0000_0800);
        // U and J formats
        add_entry(32'h1234_5037, 1'b1, 3'b100, 7'b1001000, SIZE_NONE, ALU_ADD, 32'h1234_5000);
        add_entry(32'hFFFF_F017, 1'b1, 3'b100, 7'b1001000, SIZE_NONE, ALU_ADD, 32'hFFFF_F000);
        add_entry(32'hFFFF_F06F, 1'b1, 3'b100, 7'b1000001, SIZE_NONE, ALU_ADD, 32'hFFFF_FFFE);
        add_entry(32'h0050_106F, 1'b1, 3'b100, 7'b1000001, SIZE_NONE, ALU_ADD, 32'h0000_1804);
        // JALR, SYSTEM, unknown opcode
        add_entry(32'h0040_0067, 1'b1, 3'b110, 7'b1001001, SIZE_NONE, ALU_ADD, 32'h0000_0004);
        add_entry(32'h0010_0073, 1'b1, 3'b110, 7'b1001000, SIZE_NONE, ALU_ADD, 32'h0000_0001);
        add_entry(32'h0000_007F, 1'b1, 3'b111, 7'b0000000, SIZE_NONE, ALU_ADD, 32'h0);
        // Bubbles keep data fields, then a valid slot again
        add_entry(32'h0040_2003, 1'b0, 3'b110, 7'b0001100, SIZE_WORD, ALU_ADD, 32'h0000_0004);
        add_entry(32'h0050_106F, 1'b0, 3'b100, 7'b0000000, SIZE_NONE, ALU_ADD, 32'h0000_1804);
        add_entry(32'h0000_2023, 1'b0, 3'b011, 7'b0001000, SIZE_WORD, ALU_ADD, 32'h0);
        add_entry(32'hFE00_0CE3, 1'b0, 3'b011, 7'b0000000, SIZE_NONE, ALU_SUB, 32'hFFFF_FFF8);
        add_entry(32'h4000_0033, 1'b1, 3'b111, 7'b1000000, SIZE_NONE, ALU_SUB, 32'h0);
    endtask

    // Fill free register fields, present on the bus
    task automatic drive_entry(input entry_t e, output word_t instr);
        logic [31:0] rnd;
        instr = e.instr;
        rnd   = lcg_next();
        if (e.free[2]) instr[11:7]  = rnd[12:8];
        if (e.free[1]) instr[19:15] = rnd[20:16];
        if (e.free[0]) instr[24:20] = rnd[28:24];
        i_instr = instr;
        i_valid = e.valid;
    endtask

    task automatic check_entry(input entry_t e, input word_t instr);
        check_value("o_valid", 32'(o_valid), 32'(e.valid));
        check_value("o_rs1", 32'(o_rs1), 32'(instr[19:15]));
        check_value("o_rs2", 32'(o_rs2), 32'(instr[24:20]));
        check_value("o_rd", 32'(o_rd), 32'(instr[11:7]));
        check_value("o_func3", 32'(o_func3), 32'(instr[14:12]));  // Echoed for loads
        check_value("o_imm", o_imm, e.imm);
        check_value("o_alu_op", 32'(o_alu_op), 32'(e.op));
        check_value("o_reg_write", 32'(o_reg_write), 32'(e.ctrl[6]));
        check_value("o_mem_read", 32'(o_mem_read), 32'(e.ctrl[5]));
        check_value("o_mem_write", 32'(o_mem_write), 32'(e.ctrl[4]));
        check_value("o_alu_src", 32'(o_alu_src), 32'(e.ctrl[3]));
        check_value("o_mem_to_reg", 32'(o_mem_to_reg), 32'(e.ctrl[2]));
        check_value("o_branch", 32'(o_branch), 32'(e.ctrl[1]));
        check_value("o_jump", 32'(o_jump), 32'(e.ctrl[0]));
        check_value("o_data_size", 32'(o_data_size), 32'(e.size));
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        word_t sent;
        i_rst      = 1'b1;
        i_valid    = 1'b0;
        i_instr    = '0;
        rand_state = 32'h8e75_593c;
        phase      = "setup";
        build_table();
        table_built = 1'b1;
        repeat (4) @(posedge i_clk);   // Reset for 4 cycles
        @(negedge i_clk);
        i_rst = 1'b0;
        phase = "after reset";         // Nothing driven yet
        check_value("o_valid", 32'(o_valid), 32'h0);
        check_value("o_reg_write", 32'(o_reg_write), 32'h0);
        check_value("o_mem_read", 32'(o_mem_read), 32'h0);
        check_value("o_mem_write", 32'(o_mem_write), 32'h0);
        check_value("o_branch", 32'(o_branch), 32'h0);
        check_value("o_jump", 32'(o_jump), 32'h0);
        // Back to back, each result one edge after its drive
        for (int i = 0; i < table_q.size(); i++) begin
            drive_entry(table_q[i], sent);
            @(negedge i_clk);
            phase = $sformatf("entry %0d", i);
            check_entry(table_q[i], sent);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Table length plus 20 cycles of margin
    initial begin
        wait (table_built);
        #((table_q.size() + 20) * 20);
        $display("Watchdog timeout, the table run did not complete in time");
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout");
    end

endmodule

//--- project.f
source/rv_decode_pkg.sv
source/rv_ctrl_if.sv
source/base_integer_ctrl_unit.sv
source/alu_ctrl_unit.sv
source/imm_gen.sv
source/decode_stage.sv
sim/tb_clk_gen.sv
sim/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
    --top-module tb_decode_stage -Mdir obj_dir -o tb_decode_stage

# A fatal stop still leaves its output for the search below
out=$(./obj_dir/tb_decode_stage 2>&1) || true
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"
